//--- build.f
hdl/ldq_pkg.sv
hdl/ldq_entry.sv
hdl/ldq_age.sv
hdl/ldq_pick.sv
hdl/ldq_top.sv
test/ldq_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = ldq_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
PASS_MSG  = TEST OK

SOURCES = $(wildcard hdl/*.sv test/*.sv)
SIM     = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/ldq_tb.sv
`timescale 1ns/10ps

module ldq_tb
  import ldq_pkg::*;
;

  localparam int          CYCLE_LIMIT = 2000;  // all tests together run a few hundred cycles
  localparam logic [31:0] LFSR_SEED   = 32'h592ede84;

  logic     i_clk;
  logic     i_reset_n;
  logic     i_disp_valid;
  cmt_id_t  i_disp_cmt_id;
  logic     i_disp_rs1_valid;
  rnid_t    i_disp_rs1_rnid;
  logic     i_disp_rs2_valid;
  rnid_t    i_disp_rs2_rnid;
  br_mask_t i_disp_br_mask;
  logic     o_disp_ready;
  logic     i_phy_wr_valid;
  rnid_t    i_phy_wr_rnid;
  logic     o_issue_valid;
  ldq_idx_t o_issue_index;
  cmt_id_t  o_issue_cmt_id;
  logic     i_ex2_valid;
  ldq_idx_t i_ex2_index;
  ex2_haz_t i_ex2_haz;
  logic     i_lrq_full;
  logic     i_br_valid;
  br_tag_t  i_br_tag;
  logic     i_br_mispredict;
  logic     i_commit_valid;
  cmt_id_t  i_commit_cmt_id;
  logic     o_done_valid;
  cmt_id_t  o_done_cmt_id;
  logic     o_finish_valid;
  cmt_id_t  o_finish_cmt_id;
  logic     o_finish_dead;

  logic [31:0]             lfsr_state;
  logic [2**CMT_ID_W-1:0]  used_ids;  // commit ids taken in the current test
  string                   test_name;
  int                      cycle_count = 0;

  ldq_top uut (.*);

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count == CYCLE_LIMIT) begin
      report_fail("timeout, the run went past its cycle limit");
    end
  end

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic draw_cmt(output cmt_id_t id);
    logic [31:0] r;
    rand_bits(CMT_ID_W, r);
    while (used_ids[r[CMT_ID_W-1:0]]) begin  // ids must stay unique while in flight
      rand_bits(CMT_ID_W, r);
    end
    id = r[CMT_ID_W-1:0];
    used_ids[id] = 1'b1;
  endtask

  task automatic draw_rnid(output rnid_t id);
    logic [31:0] r;
    rand_bits(RNID_W, r);
    id = r[RNID_W-1:0];
  endtask

  task automatic compare_cmt(input string what, input cmt_id_t exp, input cmt_id_t act);
    if (exp !== act) begin
      report_fail($sformatf("Mismatch in %s: %s expected %0h actual %0h",
                            test_name, what, exp, act));
    end
  endtask

  task automatic compare_idx(input string what, input ldq_idx_t exp, input ldq_idx_t act);
    if (exp !== act) begin
      report_fail($sformatf("Mismatch in %s: %s expected %0d actual %0d",
                            test_name, what, exp, act));
    end
  endtask

  task automatic compare_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      report_fail($sformatf("Mismatch in %s: %s expected %0b actual %0b",
                            test_name, what, exp, act));
    end
  endtask

  task automatic clear_strobes();
    i_disp_valid    = 1'b0;
    i_phy_wr_valid  = 1'b0;
    i_ex2_valid     = 1'b0;
    i_br_valid      = 1'b0;
    i_br_mispredict = 1'b0;
    i_commit_valid  = 1'b0;
  endtask

  // one cycle on, inputs change at the falling edge
  task automatic next_cycle();
    @(posedge i_clk);
    @(negedge i_clk);
    clear_strobes();
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    used_ids  = '0;
    $display("running %s", name);
  endtask

  task automatic dispatch(input cmt_id_t cmt, input logic rs1_v, input rnid_t rs1,
                          input logic rs2_v, input rnid_t rs2, input br_mask_t mask);
    compare_bit("disp ready at dispatch", 1'b1, o_disp_ready);
    i_disp_valid     = 1'b1;
    i_disp_cmt_id    = cmt;
    i_disp_rs1_valid = rs1_v;
    i_disp_rs1_rnid  = rs1;
    i_disp_rs2_valid = rs2_v;
    i_disp_rs2_rnid  = rs2;
    i_disp_br_mask   = mask;
  endtask

  task automatic wakeup(input rnid_t id);
    i_phy_wr_valid = 1'b1;
    i_phy_wr_rnid  = id;
  endtask

  task automatic ex2_report(input ldq_idx_t idx, input ex2_haz_t haz);
    i_ex2_valid = 1'b1;
    i_ex2_index = idx;
    i_ex2_haz   = haz;
  endtask

  task automatic branch(input br_tag_t tag, input logic mispredict);
    i_br_valid      = 1'b1;
    i_br_tag        = tag;
    i_br_mispredict = mispredict;
  endtask

  task automatic commit(input cmt_id_t cmt);
    i_commit_valid  = 1'b1;
    i_commit_cmt_id = cmt;
  endtask

  task automatic expect_issue(input int max_cycles, input ldq_idx_t exp_idx,
                              input cmt_id_t exp_cmt);
    int n;
    n = 0;
    #1;
    while (!o_issue_valid) begin
      if (n == max_cycles) begin
        report_fail($sformatf("%s: no issue within %0d cycles", test_name, max_cycles));
      end
      next_cycle();
      #1;
      n++;
    end
    compare_idx("issue index", exp_idx, o_issue_index);
    compare_cmt("issue cmt id", exp_cmt, o_issue_cmt_id);
  endtask

  // ex2 clean, one done cycle, then commit
  task automatic finish_load(input ldq_idx_t idx, input cmt_id_t cmt);
    next_cycle();
    ex2_report(idx, HAZ_NONE);
    next_cycle();
    #1;
    compare_bit("done valid", 1'b1, o_done_valid);
    compare_cmt("done cmt id", cmt, o_done_cmt_id);
    next_cycle();
    commit(cmt);
    #1;
    compare_bit("done after one cycle", 1'b0, o_done_valid);
    compare_bit("finish valid", 1'b1, o_finish_valid);
    compare_cmt("finish cmt id", cmt, o_finish_cmt_id);
    compare_bit("finish dead", 1'b0, o_finish_dead);
  endtask

  task automatic commit_dead(input cmt_id_t cmt);
    next_cycle();
    commit(cmt);
    #1;
    compare_bit("finish valid of killed load", 1'b1, o_finish_valid);
    compare_cmt("finish cmt id", cmt, o_finish_cmt_id);
    compare_bit("finish dead", 1'b1, o_finish_dead);
  endtask

  task automatic test_single_load();
    cmt_id_t cmt;
    rnid_t   src;
    begin_test("single_load");
    draw_cmt(cmt);
    draw_rnid(src);
    next_cycle();
    dispatch(cmt, 1'b1, src, 1'b1, src, '0);
    wakeup(src);  // same-cycle wakeup
    next_cycle();
    #1;
    compare_bit("issue valid one cycle after dispatch", 1'b0, o_issue_valid);
    next_cycle();
    #1;
    compare_bit("issue valid two cycles after dispatch", 1'b1, o_issue_valid);
    compare_idx("issue index", ldq_idx_t'(0), o_issue_index);
    compare_cmt("issue cmt id", cmt, o_issue_cmt_id);
    finish_load(ldq_idx_t'(0), cmt);
  endtask

  task automatic test_wakeup_order();
    cmt_id_t cmt_a;
    cmt_id_t cmt_b;
    cmt_id_t cmt_p;
    cmt_id_t cmt_c;
    cmt_id_t cmt_d;
    rnid_t   src_a;
    rnid_t   src_cd;
    begin_test("wakeup_order");
    draw_cmt(cmt_a);
    draw_cmt(cmt_b);
    draw_cmt(cmt_p);
    draw_cmt(cmt_c);
    draw_cmt(cmt_d);
    draw_rnid(src_a);
    draw_rnid(src_cd);
    next_cycle();
    dispatch(cmt_a, 1'b1, src_a, 1'b0, '0, '0);  // entry 0, waits
    next_cycle();
    dispatch(cmt_b, 1'b0, '0, 1'b0, '0, '0);      // entry 1, ready
    expect_issue(4, ldq_idx_t'(1), cmt_b);
    finish_load(ldq_idx_t'(1), cmt_b);
    next_cycle();
    wakeup(src_a);
    expect_issue(4, ldq_idx_t'(0), cmt_a);
    finish_load(ldq_idx_t'(0), cmt_a);
    // older load ends up at the higher index
    next_cycle();
    dispatch(cmt_p, 1'b0, '0, 1'b0, '0, '0);
    next_cycle();
    dispatch(cmt_c, 1'b0, '0, 1'b1, src_cd, '0);
    expect_issue(4, ldq_idx_t'(0), cmt_p);
    finish_load(ldq_idx_t'(0), cmt_p);
    next_cycle();
    dispatch(cmt_d, 1'b1, src_cd, 1'b0, '0, '0);
    next_cycle();
    wakeup(src_cd);
    expect_issue(4, ldq_idx_t'(1), cmt_c);
    next_cycle();
    expect_issue(0, ldq_idx_t'(0), cmt_d);
    finish_load(ldq_idx_t'(1), cmt_c);
    finish_load(ldq_idx_t'(0), cmt_d);
  endtask

  task automatic test_retry_hazards();
    cmt_id_t cmt;
    begin_test("retry_hazards");
    draw_cmt(cmt);
    next_cycle();
    dispatch(cmt, 1'b0, '0, 1'b0, '0, '0);
    expect_issue(4, ldq_idx_t'(0), cmt);
    next_cycle();
    ex2_report(ldq_idx_t'(0), HAZ_L1D_CONFLICT);
    expect_issue(4, ldq_idx_t'(0), cmt);
    next_cycle();
    i_lrq_full = 1'b1;
    ex2_report(ldq_idx_t'(0), HAZ_LRQ_FULL);
    repeat (6) begin
      next_cycle();
      #1;
      compare_bit("issue while refill queue full", 1'b0, o_issue_valid);
    end
    i_lrq_full = 1'b0;
    expect_issue(4, ldq_idx_t'(0), cmt);
    finish_load(ldq_idx_t'(0), cmt);
  endtask

  task automatic test_branch_kill();
    cmt_id_t cmt_k;
    cmt_id_t cmt_l;
    cmt_id_t cmt_n;
    cmt_id_t cmt_m;
    rnid_t   src_k;
    rnid_t   src_l;
    begin_test("branch_kill");
    draw_cmt(cmt_k);
    draw_cmt(cmt_l);
    draw_cmt(cmt_n);
    draw_cmt(cmt_m);
    draw_rnid(src_k);
    src_l = ~src_k;  // distinct from src_k
    next_cycle();
    dispatch(cmt_k, 1'b1, src_k, 1'b0, '0, 4'b0010);  // entry 0, waits
    next_cycle();
    dispatch(cmt_l, 1'b1, src_l, 1'b0, '0, 4'b0100);  // entry 1, other branch
    next_cycle();
    dispatch(cmt_n, 1'b0, '0, 1'b0, '0, 4'b0010);     // entry 2, ready
    expect_issue(4, ldq_idx_t'(2), cmt_n);
    next_cycle();
    ex2_report(ldq_idx_t'(2), HAZ_NONE);
    next_cycle();
    dispatch(cmt_m, 1'b0, '0, 1'b0, '0, 4'b0010);  // killed in its dispatch cycle
    branch(2'd1, 1'b1);
    #1;
    compare_bit("done of load killed in its done cycle", 1'b0, o_done_valid);
    next_cycle();
    wakeup(src_k);
    repeat (5) begin
      next_cycle();
      #1;
      compare_bit("issue of killed load", 1'b0, o_issue_valid);
      compare_bit("done of killed load", 1'b0, o_done_valid);
    end
    next_cycle();
    wakeup(src_l);
    expect_issue(4, ldq_idx_t'(1), cmt_l);
    branch(2'd2, 1'b0);  // resolves right
    finish_load(ldq_idx_t'(1), cmt_l);
    commit_dead(cmt_k);
    commit_dead(cmt_n);
    commit_dead(cmt_m);
  endtask

  task automatic test_capacity();
    cmt_id_t ids [LDQ_SIZE];
    rnid_t   src_z;
    begin_test("capacity");
    draw_rnid(src_z);
    for (int i = 0; i < LDQ_SIZE; i++) begin
      draw_cmt(ids[i]);
      next_cycle();
      dispatch(ids[i], 1'b1, src_z, 1'b0, '0, '0);
    end
    next_cycle();
    compare_bit("disp ready when full", 1'b0, o_disp_ready);
    wakeup(src_z);
    expect_issue(4, ldq_idx_t'(0), ids[0]);
    for (int i = 1; i < LDQ_SIZE; i++) begin
      next_cycle();
      expect_issue(0, ldq_idx_t'(i), ids[i]);
    end
    finish_load(ldq_idx_t'(0), ids[0]);
    compare_bit("disp ready in finish cycle", 1'b0, o_disp_ready);
    next_cycle();
    compare_bit("disp ready after finish", 1'b1, o_disp_ready);
    for (int i = 1; i < LDQ_SIZE; i++) begin
      finish_load(ldq_idx_t'(i), ids[i]);
    end
  endtask

  initial begin
    lfsr_state       = LFSR_SEED;
    used_ids         = '0;
    test_name        = "reset";
    i_reset_n        = 1'b0;
    i_disp_cmt_id    = '0;
    i_disp_rs1_valid = 1'b0;
    i_disp_rs1_rnid  = '0;
    i_disp_rs2_valid = 1'b0;
    i_disp_rs2_rnid  = '0;
    i_disp_br_mask   = '0;
    i_phy_wr_rnid    = '0;
    i_ex2_index      = '0;
    i_ex2_haz        = HAZ_NONE;
    i_lrq_full       = 1'b0;
    i_br_tag         = '0;
    i_commit_cmt_id  = '0;
    clear_strobes();
    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    #1;
    compare_bit("issue valid after reset", 1'b0, o_issue_valid);
    compare_bit("done valid after reset", 1'b0, o_done_valid);
    compare_bit("finish valid after reset", 1'b0, o_finish_valid);
    compare_bit("disp ready after reset", 1'b1, o_disp_ready);
    test_single_load();
    test_wakeup_order();
    test_retry_hazards();
    test_branch_kill();
    test_capacity();
    $display("TEST OK");
    $finish;
  end

endmodule

//--- hdl/ldq_top.sv
`timescale 1ns/10ps

module ldq_top
  import ldq_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset_n,

  input  logic     i_disp_valid,
  input  cmt_id_t  i_disp_cmt_id,
  input  logic     i_disp_rs1_valid,
  input  rnid_t    i_disp_rs1_rnid,
  input  logic     i_disp_rs2_valid,
  input  rnid_t    i_disp_rs2_rnid,
  input  br_mask_t i_disp_br_mask,
  output logic     o_disp_ready,

  input  logic     i_phy_wr_valid,
  input  rnid_t    i_phy_wr_rnid,

  output logic     o_issue_valid,
  output ldq_idx_t o_issue_index,
  output cmt_id_t  o_issue_cmt_id,

  input  logic     i_ex2_valid,
  input  ldq_idx_t i_ex2_index,
  input  ex2_haz_t i_ex2_haz,
  input  logic     i_lrq_full,

  input  logic     i_br_valid,
  input  br_tag_t  i_br_tag,
  input  logic     i_br_mispredict,

  input  logic     i_commit_valid,
  input  cmt_id_t  i_commit_cmt_id,

  output logic     o_done_valid,
  output cmt_id_t  o_done_cmt_id,
  output logic     o_finish_valid,
  output cmt_id_t  o_finish_cmt_id,
  output logic     o_finish_dead
);

  ldq_vec_t w_alloc;
  ldq_vec_t w_valid;
  ldq_vec_t w_ready;
  ldq_vec_t w_done;
  ldq_vec_t w_finish;
  ldq_vec_t w_dead;
  ldq_vec_t w_pick;
  ldq_vec_t w_ex2_valid;
  ldq_vec_t w_older [LDQ_SIZE];
  cmt_id_t  w_cmt_id [LDQ_SIZE];

  cmt_id_t  w_issue_cmt_id;
  cmt_id_t  r_issue_cmt_id;

  generate
    for (genvar i = 0; i < LDQ_SIZE; i++) begin : g_entry
      assign w_ex2_valid[i] = i_ex2_valid & (i_ex2_index == ldq_idx_t'(i));

      ldq_entry u_entry (
        .i_clk            (i_clk),
        .i_reset_n        (i_reset_n),
        .i_alloc          (w_alloc[i]),
        .i_disp_cmt_id    (i_disp_cmt_id),
        .i_disp_rs1_valid (i_disp_rs1_valid),
        .i_disp_rs1_rnid  (i_disp_rs1_rnid),
        .i_disp_rs2_valid (i_disp_rs2_valid),
        .i_disp_rs2_rnid  (i_disp_rs2_rnid),
        .i_disp_br_mask   (i_disp_br_mask),
        .i_phy_wr_valid   (i_phy_wr_valid),
        .i_phy_wr_rnid    (i_phy_wr_rnid),
        .i_picked         (w_pick[i]),
        .i_ex2_valid      (w_ex2_valid[i]),
        .i_ex2_haz        (i_ex2_haz),
        .i_lrq_full       (i_lrq_full),
        .i_br_valid       (i_br_valid),
        .i_br_tag         (i_br_tag),
        .i_br_mispredict  (i_br_mispredict),
        .i_commit_valid   (i_commit_valid),
        .i_commit_cmt_id  (i_commit_cmt_id),
        .o_valid          (w_valid[i]),
        .o_ready          (w_ready[i]),
        .o_done           (w_done[i]),
        .o_finish         (w_finish[i]),
        .o_dead           (w_dead[i]),
        .o_cmt_id         (w_cmt_id[i])
      );
    end
  endgenerate

  ldq_age u_age (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp_valid  (i_disp_valid),
    .i_entry_valid (w_valid),
    .o_alloc       (w_alloc),
    .o_disp_ready  (o_disp_ready),
    .o_older       (w_older)
  );

  ldq_pick u_pick (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_ready       (w_ready),
    .i_older       (w_older),
    .o_pick        (w_pick),
    .o_issue_valid (o_issue_valid),
    .o_issue_index (o_issue_index)
  );

  // and-or muxes, sources are one-hot
  always_comb begin
    w_issue_cmt_id  = '0;
    o_done_cmt_id   = '0;
    o_finish_cmt_id = '0;
    for (int i = 0; i < LDQ_SIZE; i++) begin
      w_issue_cmt_id  = w_issue_cmt_id  | ({CMT_ID_W{w_pick[i]}}   & w_cmt_id[i]);
      o_done_cmt_id   = o_done_cmt_id   | ({CMT_ID_W{w_done[i]}}   & w_cmt_id[i]);
      o_finish_cmt_id = o_finish_cmt_id | ({CMT_ID_W{w_finish[i]}} & w_cmt_id[i]);
    end
  end

  assign o_done_valid   = |w_done;
  assign o_finish_valid = |w_finish;
  assign o_finish_dead  = |(w_finish & w_dead);

  // lines up with the picker's registered index
  always_ff @(posedge i_clk) begin
    r_issue_cmt_id <= w_issue_cmt_id;
  end

  assign o_issue_cmt_id = r_issue_cmt_id;

endmodule

//--- hdl/ldq_pick.sv
`timescale 1ns/10ps

module ldq_pick
  import ldq_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset_n,

  input  ldq_vec_t i_ready,
  input  ldq_vec_t i_older [LDQ_SIZE],

  output ldq_vec_t o_pick,
  output logic     o_issue_valid,
  output ldq_idx_t o_issue_index
);

  ldq_idx_t w_pick_index;
  logic     r_issue_valid;
  ldq_idx_t r_issue_index;

  // oldest ready: no ready entry ahead of it
  always_comb begin
    for (int i = 0; i < LDQ_SIZE; i++) begin
      o_pick[i] = i_ready[i] & ~|(i_older[i] & i_ready);
    end
  end

  always_comb begin
    w_pick_index = '0;
    for (int i = 0; i < LDQ_SIZE; i++) begin
      if (o_pick[i]) begin
        w_pick_index = ldq_idx_t'(i);
      end
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_issue_valid <= 1'b0;
    end else begin
      r_issue_valid <= |o_pick;
    end
  end

  always_ff @(posedge i_clk) begin
    r_issue_index <= w_pick_index;
  end

  assign o_issue_valid = r_issue_valid;
  assign o_issue_index = r_issue_index;

  // holds only while the age rows stay consistent
  a_pick_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(o_pick));

endmodule

//--- hdl/ldq_age.sv
`timescale 1ns/10ps

module ldq_age
  import ldq_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset_n,

  input  logic     i_disp_valid,
  input  ldq_vec_t i_entry_valid,

  output ldq_vec_t o_alloc,
  output logic     o_disp_ready,
  output ldq_vec_t o_older [LDQ_SIZE]
);

  ldq_vec_t w_free;
  ldq_vec_t w_lowest_free;

  // row i has bit j set when entry j was dispatched before entry i
  ldq_vec_t r_older [LDQ_SIZE];

  assign w_free = ~i_entry_valid;

  // isolate lowest set bit
  assign w_lowest_free = w_free & (~w_free + ldq_vec_t'(1));

  assign o_alloc      = i_disp_valid ? w_lowest_free : '0;
  assign o_disp_ready = |w_free;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < LDQ_SIZE; i++) begin
        r_older[i] <= '0;
      end
    end else begin
      for (int i = 0; i < LDQ_SIZE; i++) begin
        if (o_alloc[i]) begin
          r_older[i] <= i_entry_valid;  // everything still in the queue is older
        end else begin
          // new entry is younger than everyone, drop its stale column
          r_older[i] <= r_older[i] & ~o_alloc;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < LDQ_SIZE; i++) begin
      o_older[i] = r_older[i];
    end
  end

  a_no_disp_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_valid |-> o_disp_ready);

endmodule

//--- hdl/ldq_entry.sv
`timescale 1ns/10ps

module ldq_entry
  import ldq_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,

  // dispatch
  input  logic       i_alloc,
  input  cmt_id_t    i_disp_cmt_id,
  input  logic       i_disp_rs1_valid,
  input  rnid_t      i_disp_rs1_rnid,
  input  logic       i_disp_rs2_valid,
  input  rnid_t      i_disp_rs2_rnid,
  input  br_mask_t   i_disp_br_mask,

  // register write bus
  input  logic       i_phy_wr_valid,
  input  rnid_t      i_phy_wr_rnid,

  input  logic       i_picked,

  // EX2 report, already decoded for this entry
  input  logic       i_ex2_valid,
  input  ex2_haz_t   i_ex2_haz,
  input  logic       i_lrq_full,

  // branch resolution
  input  logic       i_br_valid,
  input  br_tag_t    i_br_tag,
  input  logic       i_br_mispredict,

  input  logic       i_commit_valid,
  input  cmt_id_t    i_commit_cmt_id,

  output logic       o_valid,
  output logic       o_ready,
  output logic       o_done,
  output logic       o_finish,
  output logic       o_dead,
  output cmt_id_t    o_cmt_id
);

  ldq_state_t r_state;
  ldq_state_t w_state_next;

  cmt_id_t    r_cmt_id;
  rnid_t      r_rs1_rnid;
  rnid_t      r_rs2_rnid;
  logic       r_rs1_rdy;
  logic       r_rs2_rdy;
  br_mask_t   r_br_mask;

  br_mask_t   w_br_clr;
  logic       w_rs1_disp_hit;
  logic       w_rs2_disp_hit;
  logic       w_rs1_hit;
  logic       w_rs2_hit;
  logic       w_br_flush;
  logic       w_disp_br_flush;
  logic       w_commit_match;

  // resolved tag leaves every mask, right or wrong
  assign w_br_clr = i_br_valid ? (br_mask_t'(1) << i_br_tag) : '0;

  assign w_br_flush      = i_br_valid & i_br_mispredict & r_br_mask[i_br_tag] & o_valid;
  assign w_disp_br_flush = i_br_valid & i_br_mispredict & i_disp_br_mask[i_br_tag];
  assign w_commit_match  = i_commit_valid & (i_commit_cmt_id == r_cmt_id) & o_valid;

  // wakeup against the incoming and the stored register ids
  assign w_rs1_disp_hit = i_phy_wr_valid & (i_phy_wr_rnid == i_disp_rs1_rnid);
  assign w_rs2_disp_hit = i_phy_wr_valid & (i_phy_wr_rnid == i_disp_rs2_rnid);
  assign w_rs1_hit      = i_phy_wr_valid & (i_phy_wr_rnid == r_rs1_rnid);
  assign w_rs2_hit      = i_phy_wr_valid & (i_phy_wr_rnid == r_rs2_rnid);

  assign o_valid  = r_state != INIT;
  assign o_ready  = (r_state == ISSUE_WAIT) & r_rs1_rdy & r_rs2_rdy & !w_br_flush;
  assign o_done   = (r_state == EX3_DONE) & !w_br_flush;  // killed loads never report
  assign o_dead   = r_state == DEAD;
  assign o_finish = w_commit_match & ((r_state == WAIT_COMPLETE) | (r_state == DEAD));
  assign o_cmt_id = r_cmt_id;

  always_comb begin
    w_state_next = r_state;
    case (r_state)
      INIT: begin
        if (i_alloc) begin
          w_state_next = w_disp_br_flush ? DEAD : ISSUE_WAIT;
        end
      end
      ISSUE_WAIT: begin
        if (w_br_flush) begin
          w_state_next = DEAD;
        end else if (i_picked) begin
          w_state_next = ISSUED;
        end
      end
      ISSUED: begin
        w_state_next = w_br_flush ? DEAD : EX2_RUN;
      end
      EX2_RUN: begin
        if (w_br_flush) begin
          w_state_next = DEAD;
        end else if (i_ex2_valid) begin
          case (i_ex2_haz)
            HAZ_NONE:         w_state_next = EX3_DONE;
            HAZ_LRQ_FULL:     w_state_next = LRQ_FULL;
            default:          w_state_next = ISSUE_WAIT;  // l1d conflict, replay
          endcase
        end
      end
      LRQ_FULL: begin
        if (w_br_flush) begin
          w_state_next = DEAD;
        end else if (!i_lrq_full) begin
          w_state_next = ISSUE_WAIT;
        end
      end
      EX3_DONE: begin
        w_state_next = w_br_flush ? DEAD : WAIT_COMPLETE;
      end
      WAIT_COMPLETE: begin
        if (w_commit_match) begin
          w_state_next = INIT;
        end else if (w_br_flush) begin
          w_state_next = DEAD;
        end
      end
      DEAD: begin
        if (w_commit_match) begin
          w_state_next = INIT;  // drained, free again
        end
      end
      default: w_state_next = INIT;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= INIT;
    end else begin
      r_state <= w_state_next;
    end
  end

  // entry record
  always_ff @(posedge i_clk) begin
    if (i_alloc) begin
      r_cmt_id   <= i_disp_cmt_id;
      r_rs1_rnid <= i_disp_rs1_rnid;
      r_rs2_rnid <= i_disp_rs2_rnid;
      r_rs1_rdy  <= !i_disp_rs1_valid | w_rs1_disp_hit;  // unused operand counts as ready
      r_rs2_rdy  <= !i_disp_rs2_valid | w_rs2_disp_hit;
      r_br_mask  <= i_disp_br_mask & ~w_br_clr;
    end else begin
      r_rs1_rdy  <= r_rs1_rdy | w_rs1_hit;
      r_rs2_rdy  <= r_rs2_rdy | w_rs2_hit;
      r_br_mask  <= r_br_mask & ~w_br_clr;
    end
  end

  a_ex2_in_run: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ex2_valid |-> (r_state == EX2_RUN));

  a_pick_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_picked |-> o_ready);

endmodule

//--- hdl/ldq_pkg.sv
package ldq_pkg;

  // queue geometry
  localparam int LDQ_SIZE  = 4;
  localparam int LDQ_IDX_W = $clog2(LDQ_SIZE);

  // id widths shared with the rest of the core
  localparam int CMT_ID_W  = 6;
  localparam int RNID_W    = 6;
  localparam int BR_TAG_W  = 2;
  localparam int BR_MASK_W = 4;  // one bit per in-flight branch tag

  typedef logic [LDQ_IDX_W-1:0] ldq_idx_t;
  typedef logic [LDQ_SIZE-1:0]  ldq_vec_t;
  typedef logic [CMT_ID_W-1:0]  cmt_id_t;
  typedef logic [RNID_W-1:0]    rnid_t;
  typedef logic [BR_TAG_W-1:0]  br_tag_t;
  typedef logic [BR_MASK_W-1:0] br_mask_t;

  // entry life cycle
  typedef enum logic [2:0] {
    INIT,           // free
    ISSUE_WAIT,     // waiting for operands or for the picker
    ISSUED,         // sent to the load pipe
    EX2_RUN,        // waiting for the EX2 report
    LRQ_FULL,       // parked until the refill queue has room
    EX3_DONE,       // completion reported this cycle
    WAIT_COMPLETE,  // done, waiting for commit
    DEAD            // killed by a mispredict, waiting for commit
  } ldq_state_t;

  // result reported by EX2
  typedef enum logic [1:0] {
    HAZ_NONE,
    HAZ_L1D_CONFLICT,
    HAZ_LRQ_FULL
  } ex2_haz_t;

endpackage
